// File: src/burst_pkg.sv
package burst_pkg;

	localparam int BURST_LENGTH = 16;  // beats per column burst
	localparam int BEAT_BITS = 4;      // low column bits pick the beat
	localparam int ROW_WIDTH = 16;
	localparam int COL_WIDTH = 10;
	localparam int BG_WIDTH = 2;
	localparam int BANK_WIDTH = 2;
	localparam int ADDR_WIDTH = BG_WIDTH + BANK_WIDTH + ROW_WIDTH + COL_WIDTH;

	// life cycle of one burst slot
	typedef enum logic [2:0] {
		empty,      // free for a new burst
		filling,    // open, still taking requests
		full,       // closed, waiting for the drain
		in_memory,  // command issued, data moving
		returning   // handing requests back
	} slot_state_e;

	// identifies one 16-beat burst
	typedef struct packed {
		logic [BG_WIDTH-1:0] bank_group;
		logic [BANK_WIDTH-1:0] bank;
		logic [ROW_WIDTH-1:0] row;
		logic [COL_WIDTH-BEAT_BITS-1:0] col_hi;  // column without the beat offset
	} burst_addr_t;

	// request address as it arrives, or split into burst and beat
	typedef union packed {
		logic [ADDR_WIDTH-1:0] raw;
		struct packed {
			burst_addr_t burst;
			logic [BEAT_BITS-1:0] beat;  // position inside the burst
		} fields;
	} req_addr_u;

endpackage

// File: src/slot_if.sv
`timescale 1ns/1ns

interface slot_if #(
	parameter int DATA_WIDTH = 32,
	parameter int INDEX_WIDTH = 6
);
	logic fill_en;     // write one request
	logic fill_open;   // first request of a new burst
	logic fill_close;  // filling -> full
	logic fill_write;
	burst_pkg::burst_addr_t fill_addr;
	logic [burst_pkg::BEAT_BITS-1:0] fill_beat;
	logic [DATA_WIDTH-1:0] fill_data;
	logic [INDEX_WIDTH-1:0] fill_index;

	burst_pkg::slot_state_e state;
	burst_pkg::burst_addr_t addr;
	logic is_write;
	logic [burst_pkg::BURST_LENGTH-1:0] mask;
	logic [DATA_WIDTH-1:0] beat_data;    // entry at sel_beat
	logic [INDEX_WIDTH-1:0] beat_index;  // entry at sel_beat

	logic issue;       // full -> in_memory
	logic [burst_pkg::BEAT_BITS-1:0] sel_beat;
	logic cap_en;      // store cap_data at sel_beat
	logic [DATA_WIDTH-1:0] cap_data;
	logic data_done;   // in_memory -> returning
	logic clr_beat;    // clear mask bit at sel_beat
	logic release_en;  // returning -> empty

	modport collector (
		output fill_en, fill_open, fill_close, fill_write,
		output fill_addr, fill_beat, fill_data, fill_index,
		input state, addr, is_write, mask
	);

	modport slot (
		input fill_en, fill_open, fill_close, fill_write,
		input fill_addr, fill_beat, fill_data, fill_index,
		input issue, sel_beat, cap_en, cap_data, data_done, clr_beat, release_en,
		output state, addr, is_write, mask, beat_data, beat_index
	);

	modport drain (
		output issue, sel_beat, cap_en, cap_data, data_done, clr_beat, release_en,
		input state, addr, is_write, mask, beat_data, beat_index
	);

endinterface

// File: src/burst_collector.sv
`timescale 1ns/1ns

module burst_collector #(
	parameter int NUM_SLOTS = 4,
	parameter int DATA_WIDTH = 32,
	parameter int INDEX_WIDTH = 6
) (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic req_write,
	input burst_pkg::req_addr_u req_addr,
	input logic [DATA_WIDTH-1:0] req_data,
	input logic [INDEX_WIDTH-1:0] req_index,
	output logic accept,
	slot_if.collector slots [NUM_SLOTS]
);
	localparam int SLOT_BITS = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
	localparam int CNT_BITS = $clog2(NUM_SLOTS + 1);

	burst_pkg::slot_state_e st [NUM_SLOTS];
	burst_pkg::burst_addr_t addr_a [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] wr_a;
	logic [burst_pkg::BURST_LENGTH-1:0] mask_a [NUM_SLOTS];
	logic open_valid;
	logic [SLOT_BITS-1:0] open_idx;
	logic [SLOT_BITS-1:0] new_idx;
	logic [SLOT_BITS-1:0] tgt_idx;
	logic [CNT_BITS-1:0] empty_cnt;
	logic join_ok;
	logic joining;
	logic opening;
	logic closing;
	logic [NUM_SLOTS-1:0] fill_en_vec;
	logic [NUM_SLOTS-1:0] fill_open_vec;
	logic [NUM_SLOTS-1:0] filling_vec;

	// downward scan so the lowest empty slot wins
	always_comb begin
		new_idx = '0;
		empty_cnt = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
			if (st[i] == burst_pkg::empty) begin
				new_idx = SLOT_BITS'(i);
				empty_cnt = empty_cnt + 1'b1;
			end
		end
	end

	// same burst, same type, beat not taken yet
	assign join_ok = open_valid && (addr_a[open_idx] == req_addr.fields.burst)
		&& (wr_a[open_idx] == req_write) && !mask_a[open_idx][req_addr.fields.beat];
	assign joining = req_valid && join_ok;
	assign opening = req_valid && !join_ok;
	assign closing = open_valid && !joining;  // mismatch or idle cycle
	assign tgt_idx = joining ? open_idx : new_idx;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			open_valid <= 1'b0;
			open_idx <= '0;
			accept <= 1'b0;
		end else begin
			open_valid <= req_valid;  // any request leaves a burst open
			if (opening) begin
				open_idx <= new_idx;
			end
			// empty slots left after this edge without counting releases
			accept <= (empty_cnt - CNT_BITS'(opening)) >= CNT_BITS'(2);
		end
	end

	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		assign st[i] = slots[i].state;
		assign addr_a[i] = slots[i].addr;
		assign wr_a[i] = slots[i].is_write;
		assign mask_a[i] = slots[i].mask;
		assign filling_vec[i] = (st[i] == burst_pkg::filling);
		assign fill_en_vec[i] = req_valid && (tgt_idx == SLOT_BITS'(i));
		assign fill_open_vec[i] = opening && (new_idx == SLOT_BITS'(i));
		assign slots[i].fill_en = fill_en_vec[i];
		assign slots[i].fill_open = fill_open_vec[i];
		assign slots[i].fill_close = closing && (open_idx == SLOT_BITS'(i));
		assign slots[i].fill_write = req_write;
		assign slots[i].fill_addr = req_addr.fields.burst;
		assign slots[i].fill_beat = req_addr.fields.beat;
		assign slots[i].fill_data = req_data;
		assign slots[i].fill_index = req_index;

		// fails when the arbiter ignored accept and no slot was free
		a_open_empty: assert property (@(posedge clk) disable iff (rst_n)
			fill_open_vec[i] |-> st[i] == burst_pkg::empty);
	end

	// never more than one burst open
	a_one_open: assert property (@(posedge clk) disable iff (rst_n) $onehot0(filling_vec));

endmodule

// File: src/burst_slot.sv
`timescale 1ns/1ns

module burst_slot #(
	parameter int DATA_WIDTH = 32,
	parameter int INDEX_WIDTH = 6
) (
	input logic clk,
	input logic rst_n,
	slot_if.slot port
);
	localparam int BL = burst_pkg::BURST_LENGTH;

	burst_pkg::slot_state_e state;
	burst_pkg::burst_addr_t addr;
	logic is_write;
	logic [BL-1:0] mask;
	logic [DATA_WIDTH-1:0] data_mem [BL];
	logic [INDEX_WIDTH-1:0] index_mem [BL];
	logic [BL-1:0] fill_bit;
	logic [BL-1:0] sel_bit;

	assign fill_bit = BL'(1) << port.fill_beat;
	assign sel_bit = BL'(1) << port.sel_beat;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state <= burst_pkg::empty;
			mask <= '0;
		end else begin
			// strobes are exclusive by state
			if (port.fill_en && port.fill_open) begin
				state <= burst_pkg::filling;
			end else if (port.fill_close) begin
				state <= burst_pkg::full;
			end else if (port.issue) begin
				state <= burst_pkg::in_memory;
			end else if (port.data_done) begin
				state <= burst_pkg::returning;
			end else if (port.release_en) begin
				state <= burst_pkg::empty;
			end

			if (port.fill_en) begin
				mask <= (port.fill_open ? '0 : mask) | fill_bit;  // open drops old bits
			end else if (port.clr_beat) begin
				mask <= mask & ~sel_bit;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (port.fill_en && port.fill_open) begin
			addr <= port.fill_addr;
			is_write <= port.fill_write;
		end
		if (port.fill_en) begin
			data_mem[port.fill_beat] <= port.fill_data;  // read beats overwritten later
			index_mem[port.fill_beat] <= port.fill_index;
		end else if (port.cap_en) begin
			data_mem[port.sel_beat] <= port.cap_data;
		end
	end

	assign port.state = state;
	assign port.addr = addr;
	assign port.is_write = is_write;
	assign port.mask = mask;
	assign port.beat_data = data_mem[port.sel_beat];
	assign port.beat_index = index_mem[port.sel_beat];

	a_fill_state: assert property (@(posedge clk) disable iff (rst_n)
		port.fill_en |->
			state == (port.fill_open ? burst_pkg::empty : burst_pkg::filling));

	a_close_state: assert property (@(posedge clk) disable iff (rst_n)
		port.fill_close |-> state == burst_pkg::filling);

	a_issue_state: assert property (@(posedge clk) disable iff (rst_n)
		port.issue |-> state == burst_pkg::full);

	a_data_state: assert property (@(posedge clk) disable iff (rst_n)
		(port.cap_en || port.data_done) |-> state == burst_pkg::in_memory);

	// drain only clears beats that were actually gathered
	a_clr_state: assert property (@(posedge clk) disable iff (rst_n)
		port.clr_beat |-> state == burst_pkg::returning && mask[port.sel_beat]);

	a_release_state: assert property (@(posedge clk) disable iff (rst_n)
		port.release_en |-> state == burst_pkg::returning && mask == '0);

endmodule

// File: src/burst_drain.sv
`timescale 1ns/1ns

module burst_drain #(
	parameter int NUM_SLOTS = 4,
	parameter int DATA_WIDTH = 32,
	parameter int INDEX_WIDTH = 6,
	parameter int WR_TO_DATA = 8
) (
	input logic clk,
	input logic rst_n,
	slot_if.drain slots [NUM_SLOTS],
	output logic mem_cmd,
	output logic mem_cmd_write,
	output burst_pkg::burst_addr_t mem_cmd_addr,
	output logic mem_wvalid,
	output logic mem_wmask,
	output logic [DATA_WIDTH-1:0] mem_wdata,
	input logic mem_rvalid,
	input logic [DATA_WIDTH-1:0] mem_rdata,
	output logic ret_valid,
	output logic ret_write,
	output logic [DATA_WIDTH-1:0] ret_data,
	output logic [INDEX_WIDTH-1:0] ret_index
);
	localparam int SLOT_BITS = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
	localparam int BL = burst_pkg::BURST_LENGTH;
	localparam int BB = burst_pkg::BEAT_BITS;
	localparam int WAIT_BITS = $clog2(WR_TO_DATA);
	localparam int WAIT_LOAD = WR_TO_DATA - 3;  // cmd edge and first beat register eat two
	localparam logic [2:0] PH_IDLE = 3'd0;
	localparam logic [2:0] PH_CMD = 3'd1;
	localparam logic [2:0] PH_WAIT = 3'd2;
	localparam logic [2:0] PH_DATA = 3'd3;
	localparam logic [2:0] PH_RET = 3'd4;

	logic [2:0] phase;
	logic [SLOT_BITS-1:0] cur;
	logic [WAIT_BITS-1:0] wait_cnt;
	logic [BB:0] beat_cnt;  // counts to 16
	burst_pkg::slot_state_e st [NUM_SLOTS];
	burst_pkg::burst_addr_t addr_a [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] wr_a;
	logic [BL-1:0] mask_a [NUM_SLOTS];
	logic [DATA_WIDTH-1:0] data_a [NUM_SLOTS];
	logic [INDEX_WIDTH-1:0] index_a [NUM_SLOTS];
	logic [SLOT_BITS-1:0] full_idx;
	logic full_found;
	logic [BL-1:0] cur_mask;
	logic [BL-1:0] first_one;
	logic [BB-1:0] first_id;
	logic cur_write;
	logic beats_done;
	logic [BB-1:0] sel_beat;
	logic issue;
	logic cap_en;
	logic data_done;
	logic clr_beat;
	logic release_en;

	always_comb begin
		full_idx = '0;
		full_found = 1'b0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
			if (st[i] == burst_pkg::full) begin
				full_idx = SLOT_BITS'(i);  // lowest full slot
				full_found = 1'b1;
			end
		end
	end

	assign cur_mask = mask_a[cur];
	assign cur_write = wr_a[cur];
	assign first_one = cur_mask & (~cur_mask + 1'b1);  // isolate lowest set bit

	always_comb begin
		first_id = '0;
		for (int b = 0; b < BL; b++) begin
			if (first_one[b]) begin
				first_id = BB'(b);
			end
		end
	end

	assign beats_done = beat_cnt[BB];
	assign sel_beat = (phase == PH_RET) ? first_id : beat_cnt[BB-1:0];
	assign issue = (phase == PH_CMD);
	assign cap_en = (phase == PH_DATA) && !cur_write && mem_rvalid && !beats_done;
	assign data_done = (phase == PH_DATA) && beats_done;
	assign clr_beat = (phase == PH_RET) && (cur_mask != '0);
	assign release_en = (phase == PH_RET) && (cur_mask == '0);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			phase <= PH_IDLE;
			mem_cmd <= 1'b0;
			mem_wvalid <= 1'b0;
			ret_valid <= 1'b0;
			wait_cnt <= '0;
			beat_cnt <= '0;
		end else begin
			mem_cmd <= 1'b0;
			ret_valid <= clr_beat;  // one return per set mask bit
			case (phase)
				PH_IDLE: begin
					if (full_found) begin
						phase <= PH_CMD;
						mem_cmd <= 1'b1;
					end
				end
				PH_CMD: begin
					wait_cnt <= WAIT_BITS'(WAIT_LOAD);
					beat_cnt <= '0;
					phase <= cur_write ? PH_WAIT : PH_DATA;  // reads wait on mem_rvalid
				end
				PH_WAIT: begin
					if (wait_cnt == '0) begin
						phase <= PH_DATA;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				PH_DATA: begin
					if (beats_done) begin
						phase <= PH_RET;
						mem_wvalid <= 1'b0;
					end else if (cur_write) begin
						mem_wvalid <= 1'b1;
						beat_cnt <= beat_cnt + 1'b1;
					end else if (mem_rvalid) begin
						beat_cnt <= beat_cnt + 1'b1;
					end
				end
				PH_RET: begin
					if (release_en) begin
						phase <= PH_IDLE;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == PH_IDLE) begin
			cur <= full_idx;
			mem_cmd_write <= wr_a[full_idx];
			mem_cmd_addr <= addr_a[full_idx];
		end
		if (phase == PH_DATA && cur_write) begin
			mem_wmask <= cur_mask[sel_beat];
			mem_wdata <= cur_mask[sel_beat] ? data_a[cur] : '0;  // zero on unused beats
		end
		if (clr_beat) begin
			ret_write <= cur_write;
			ret_data <= data_a[cur];
			ret_index <= index_a[cur];
		end
	end

	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		assign st[i] = slots[i].state;
		assign addr_a[i] = slots[i].addr;
		assign wr_a[i] = slots[i].is_write;
		assign mask_a[i] = slots[i].mask;
		assign data_a[i] = slots[i].beat_data;
		assign index_a[i] = slots[i].beat_index;
		assign slots[i].issue = issue && (cur == SLOT_BITS'(i));
		assign slots[i].sel_beat = sel_beat;
		assign slots[i].cap_en = cap_en && (cur == SLOT_BITS'(i));
		assign slots[i].cap_data = mem_rdata;
		assign slots[i].data_done = data_done && (cur == SLOT_BITS'(i));
		assign slots[i].clr_beat = clr_beat && (cur == SLOT_BITS'(i));
		assign slots[i].release_en = release_en && (cur == SLOT_BITS'(i));
	end

	// the memory answers only a read burst and never with more than 16 beats
	a_rvalid_window: assert property (@(posedge clk) disable iff (rst_n)
		mem_rvalid |-> phase == PH_DATA && !cur_write && !beats_done);

endmodule

// File: src/burst_engine_top.sv
`timescale 1ns/1ns

module burst_engine_top #(
	parameter int NUM_SLOTS = 4,
	parameter int DATA_WIDTH = 32,
	parameter int INDEX_WIDTH = 6,
	parameter int WR_TO_DATA = 8
) (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic req_write,
	input logic [burst_pkg::ADDR_WIDTH-1:0] req_addr,  // raw address word
	input logic [DATA_WIDTH-1:0] req_data,
	input logic [INDEX_WIDTH-1:0] req_index,
	output logic accept,
	output logic mem_cmd,
	output logic mem_cmd_write,
	output burst_pkg::burst_addr_t mem_cmd_addr,
	output logic mem_wvalid,
	output logic mem_wmask,
	output logic [DATA_WIDTH-1:0] mem_wdata,
	input logic mem_rvalid,
	input logic [DATA_WIDTH-1:0] mem_rdata,
	output logic ret_valid,
	output logic ret_write,
	output logic [DATA_WIDTH-1:0] ret_data,
	output logic [INDEX_WIDTH-1:0] ret_index
);
	slot_if #(.DATA_WIDTH(DATA_WIDTH), .INDEX_WIDTH(INDEX_WIDTH)) slots [NUM_SLOTS] ();

	burst_collector #(
		.NUM_SLOTS(NUM_SLOTS),
		.DATA_WIDTH(DATA_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH)
	) u_collector (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_data(req_data),
		.req_index(req_index),
		.accept(accept),
		.slots(slots)
	);

	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		burst_slot #(
			.DATA_WIDTH(DATA_WIDTH),
			.INDEX_WIDTH(INDEX_WIDTH)
		) u_slot (
			.clk(clk),
			.rst_n(rst_n),
			.port(slots[i])
		);
	end

	burst_drain #(
		.NUM_SLOTS(NUM_SLOTS),
		.DATA_WIDTH(DATA_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.WR_TO_DATA(WR_TO_DATA)
	) u_drain (
		.clk(clk),
		.rst_n(rst_n),
		.slots(slots),
		.mem_cmd(mem_cmd),
		.mem_cmd_write(mem_cmd_write),
		.mem_cmd_addr(mem_cmd_addr),
		.mem_wvalid(mem_wvalid),
		.mem_wmask(mem_wmask),
		.mem_wdata(mem_wdata),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.ret_valid(ret_valid),
		.ret_write(ret_write),
		.ret_data(ret_data),
		.ret_index(ret_index)
	);

endmodule

// File: dv/tb_burst_model.svh
`ifndef TB_BURST_MODEL_SVH
`define TB_BURST_MODEL_SVH

// bursts as the formation rule builds them
burst_pkg::burst_addr_t b_addr [NUM_REQ];
logic b_write [NUM_REQ];
logic [BL-1:0] b_mask [NUM_REQ];
logic [31:0] b_data [NUM_REQ][BL];
bit b_used [NUM_REQ];  // already matched to a memory burst
int b_count;
int busy_slots;  // opened and not yet released
bit open_valid;
int open_id;

// requests filed under their index
int r_burst [NUM_REQ];
int r_beat [NUM_REQ];
logic r_write [NUM_REQ];
logic [29:0] r_addr [NUM_REQ];
logic [31:0] r_data [NUM_REQ];
bit r_seen [NUM_REQ];
bit r_done [NUM_REQ];

logic [31:0] model_mem [logic [29:0]];  // writes applied in memory order

function automatic logic [31:0] fill_value(logic [29:0] a);
	return {2'b10, a} ^ (32'(a) * 32'h9e37_79b1);  // every address bit matters
endfunction

task automatic take_request(logic wr, burst_pkg::req_addr_u a, logic [31:0] d, int idx);
	logic joins;
	joins = open_valid && b_addr[open_id] == a.fields.burst && b_write[open_id] == wr
		&& !b_mask[open_id][a.fields.beat];
	if (!joins) begin
		open_id = b_count;  // old burst closes here
		b_count++;
		busy_slots++;
		b_addr[open_id] = a.fields.burst;
		b_write[open_id] = wr;
		b_mask[open_id] = '0;
	end
	open_valid = 1'b1;
	b_mask[open_id][a.fields.beat] = 1'b1;
	b_data[open_id][a.fields.beat] = d;
	r_burst[idx] = open_id;
	r_beat[idx] = int'(a.fields.beat);
	r_write[idx] = wr;
	r_addr[idx] = a.raw;
	r_data[idx] = d;
	r_seen[idx] = 1'b1;
endtask

task automatic apply_write(int b);
	for (int i = 0; i < BL; i++) begin
		if (b_mask[b][i]) begin
			model_mem[{b_addr[b], 4'(i)}] = b_data[b][i];
		end
	end
endtask

function automatic logic [31:0] expected_data(int idx);
	if (r_write[idx]) begin
		return r_data[idx];
	end
	return model_mem.exists(r_addr[idx]) ? model_mem[r_addr[idx]] : fill_value(r_addr[idx]);
endfunction

`endif

// File: dv/tb_burst_engine.sv
`timescale 1ns/1ns

module tb_burst_engine;

	localparam int NUM_SLOTS = 4;
	localparam int WR_TO_DATA = 8;
	localparam int NUM_REQ = 64;  // one request per index value
	localparam int BL = burst_pkg::BURST_LENGTH;
	localparam logic [31:0] SEED = 32'h0106_344e;

	logic clk;
	logic rst_n;
	logic req_valid;
	logic req_write;
	logic [burst_pkg::ADDR_WIDTH-1:0] req_addr;
	logic [31:0] req_data;
	logic [5:0] req_index;
	logic accept;
	logic mem_cmd;
	logic mem_cmd_write;
	burst_pkg::burst_addr_t mem_cmd_addr;
	logic mem_wvalid;
	logic mem_wmask;
	logic [31:0] mem_wdata;
	logic mem_rvalid;
	logic [31:0] mem_rdata;
	logic ret_valid;
	logic ret_write;
	logic [31:0] ret_data;
	logic [5:0] ret_index;

	int value_errs;
	int other_errs;
	int cyc;
	int wr_start = -1000;  // first write beat cycle
	int cmd_count;
	burst_pkg::burst_addr_t cmd_addr;
	logic cmd_write;
	bit cmd_fresh;
	int cur_b;
	int ret_left;
	int last_beat;
	int returned;
	logic cap_mask [BL];
	logic [31:0] cap_data [BL];
	logic [31:0] resp_mem [logic [29:0]];  // memory behind the DUT

	`include "tb_burst_model.svh"

	burst_engine_top UUT (.*);

	always #20 clk = ~clk;

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic note_failure(string msg);
		other_errs++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	function automatic burst_pkg::burst_addr_t random_burst();
		burst_pkg::burst_addr_t b;
		b.bank_group = 2'($urandom_range(0, 3));
		b.bank = 2'($urandom_range(0, 1));
		b.row = 16'($urandom_range(0, 1));
		b.col_hi = 6'($urandom_range(0, 1));  // small pool so reads hit old writes
		return b;
	endfunction

	task automatic take_return();
		int idx;
		idx = int'(ret_index);
		if (!r_seen[idx] || r_done[idx]) begin
			note_failure($sformatf("return with unknown or repeated index %0d", idx));
			return;
		end
		if (ret_left == 0) begin
			if (!cmd_fresh) begin
				note_failure("burst returned without a mem_cmd");
			end
			cmd_fresh = 1'b0;
			cur_b = r_burst[idx];
			if (b_used[cur_b]) begin
				note_failure("same burst returned twice");
			end
			b_used[cur_b] = 1'b1;
			ret_left = $countones(b_mask[cur_b]);
			last_beat = -1;
			check_value("mem_cmd_addr", 32'(cmd_addr), 32'(b_addr[cur_b]));
			check_value("mem_cmd_write", 32'(cmd_write), 32'(b_write[cur_b]));
			if (b_write[cur_b]) begin
				for (int i = 0; i < BL; i++) begin
					check_value("mem_wmask", 32'(cap_mask[i]), 32'(b_mask[cur_b][i]));
					check_value("mem_wdata", cap_data[i],
						b_mask[cur_b][i] ? b_data[cur_b][i] : 32'd0);
				end
				apply_write(cur_b);
			end
		end else if (r_burst[idx] != cur_b) begin
			note_failure($sformatf("index %0d returned inside another burst", idx));
		end
		if (r_beat[idx] <= last_beat) begin
			note_failure($sformatf("index %0d returned out of beat order", idx));
		end
		last_beat = r_beat[idx];
		check_value("ret_write", 32'(ret_write), 32'(r_write[idx]));
		check_value("ret_data", ret_data, expected_data(idx));
		r_done[idx] = 1'b1;
		returned++;
		ret_left--;
		if (ret_left == 0) begin
			busy_slots--;  // slot goes empty on this edge
		end
	endtask

	// samples pre-edge values, runs the model and the checks
	always @(posedge clk) begin : monitor
		burst_pkg::req_addr_u a;
		logic exp_wvalid;
		if (!rst_n) begin
			cyc++;
			if (NUM_SLOTS - busy_slots < 2) begin
				check_value("accept", 32'(accept), 32'd0);
			end
			a.raw = req_addr;
			if (req_valid) begin
				take_request(req_write, a, req_data, int'(req_index));
			end else begin
				open_valid = 1'b0;  // idle cycle closes the burst
			end
			if (mem_cmd) begin
				if (ret_left != 0) begin
					note_failure("mem_cmd while a burst is still returning");
				end
				cmd_count++;
				cmd_fresh = 1'b1;
				cmd_addr = mem_cmd_addr;
				cmd_write = mem_cmd_write;
				wr_start = mem_cmd_write ? cyc + WR_TO_DATA : -1000;
			end
			exp_wvalid = (cyc >= wr_start) && (cyc < wr_start + BL);
			check_value("mem_wvalid", 32'(mem_wvalid), 32'(exp_wvalid));
			if (exp_wvalid) begin
				cap_mask[cyc - wr_start] = mem_wmask;
				cap_data[cyc - wr_start] = mem_wdata;
			end
			if (ret_valid) begin
				take_return();
			end
		end
	end

	// memory responder, write sink and read beats with random gaps
	always @(posedge clk) begin : memory
		logic [29:0] k;
		burst_pkg::burst_addr_t resp_addr;
		int resp_beat;
		int rd_left;
		int rd_delay;
		mem_rvalid <= 1'b0;
		if (mem_cmd) begin
			resp_addr = mem_cmd_addr;
			resp_beat = 0;
			rd_left = mem_cmd_write ? 0 : BL;
			rd_delay = $urandom_range(0, 6);  // read latency
		end else if (mem_wvalid) begin
			if (mem_wmask) begin
				resp_mem[{resp_addr, 4'(resp_beat)}] = mem_wdata;
			end
			resp_beat++;
		end else if (rd_left != 0) begin
			if (rd_delay != 0) begin
				rd_delay--;
			end else begin
				k = {resp_addr, 4'(resp_beat)};
				mem_rvalid <= 1'b1;
				mem_rdata <= resp_mem.exists(k) ? resp_mem[k] : fill_value(k);
				resp_beat++;
				rd_left--;
				rd_delay = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 2) : 0;
			end
		end
	end

	initial begin : main
		burst_pkg::req_addr_u a;
		burst_pkg::burst_addr_t run_addr;
		logic run_write;
		int n;
		void'($urandom(SEED));
		clk = 1'b0;
		rst_n = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_data = '0;
		req_index = '0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		repeat (16) @(posedge clk);
		check_value("accept", 32'(accept), 32'd0);
		check_value("mem_cmd", 32'(mem_cmd), 32'd0);
		check_value("mem_wvalid", 32'(mem_wvalid), 32'd0);
		check_value("ret_valid", 32'(ret_valid), 32'd0);
		rst_n <= 1'b0;
		run_addr = random_burst();
		run_write = 1'b1;
		n = 0;
		while (n < NUM_REQ) begin
			@(posedge clk);
			if (accept && $urandom_range(0, 99) >= 12) begin
				if ($urandom_range(0, 99) < 25) begin
					run_addr = random_burst();
				end
				if ($urandom_range(0, 99) < 20) begin
					run_write = !run_write;
				end
				a.fields.burst = run_addr;
				a.fields.beat = 4'($urandom_range(0, 15));  // repeats close the burst
				req_valid <= 1'b1;
				req_write <= run_write;
				req_addr <= a.raw;
				req_data <= $urandom();
				req_index <= 6'(n);
				n++;
			end else begin
				req_valid <= 1'b0;  // idle gap or back-pressure
			end
		end
		@(posedge clk);
		req_valid <= 1'b0;
		wait (returned == NUM_REQ);
		repeat (8) @(posedge clk);
		check_value("mem_cmd count", 32'(cmd_count), 32'(b_count));
		if (ret_left != 0) begin
			note_failure("last burst did not finish its returns");
		end
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// each request gets a generous share of drain time
	initial begin : watchdog
		repeat (NUM_REQ * 200 + 1000) @(posedge clk);
		$display("timeout: %0d of %0d requests returned, %0d value mismatches, %0d other failures",
			returned, NUM_REQ, value_errs, other_errs);
		$display("sim failed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+dv
src/burst_pkg.sv
src/slot_if.sv
src/burst_collector.sv
src/burst_slot.sv
src/burst_drain.sv
src/burst_engine_top.sv
dv/tb_burst_engine.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_burst_engine -f sim.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "result: PASS" || { echo "result: FAIL"; exit 1; }
